//--- src/geometry_pkg.sv
package geometry_pkg;

	// one image pixel as stored in DDR
	typedef logic [15:0] pixel_t;

	// row, column and layer counts and indices
	typedef logic [9:0] dim_t;

	// 3x3 window, element 3*i + j at bits 16*(3*i + j)
	// i selects the row (0 is the upper one), j the column
	typedef logic [143:0] window_t;

	// pixels carried by one 128-bit beat
	localparam int PIX_PER_BEAT = 8;

endpackage

//--- src/ddr_read_pkg.sv
package ddr_read_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [127:0] beat_t;
	typedef logic [7:0] burst_len_t;

	// ---------------------------------------------------------------------------
	// fixed AXI read address fields
	// ---------------------------------------------------------------------------

	// 16 bytes per beat
	localparam logic [2:0] AR_SIZE_16B = 3'd4;
	localparam logic [1:0] AR_BURST_INCR = 2'd1;
	localparam logic [3:0] READ_ID = 4'd1;

endpackage

//--- src/reader_ifs.sv
// row fetch request, four-phase req/ack
interface row_fetch_if import ddr_read_pkg::*; ();
	logic req;
	addr_t row_addr;
	logic [1:0] line_sel;
	logic ack;

	modport requester (output req, row_addr, line_sel, input ack);
	modport server (input req, row_addr, line_sel, output ack);
endinterface

// beat writes into one of the three line memories
interface line_write_if import ddr_read_pkg::*; ();
	logic we;
	logic [1:0] line_sel;
	burst_len_t beat_idx;
	beat_t data;

	modport source (output we, line_sel, beat_idx, data);
	modport sink (input we, line_sel, beat_idx, data);
endinterface

//--- src/reader_config.sv
module reader_config import geometry_pkg::*, ddr_read_pkg::*; #(
	parameter int MAX_COLS = 64
) (
	input logic clk,
	input logic reset_n,
	input logic start,
	input logic run_end,
	input addr_t base_addr,
	input dim_t rows,
	input dim_t cols,
	input dim_t layers,
	input addr_t row_bytes,
	output addr_t cfg_base,
	output addr_t cfg_row_bytes,
	output dim_t cfg_rows,
	output dim_t cfg_cols,
	output dim_t cfg_layers,
	output burst_len_t row_beats,
	output logic busy,
	output logic done
);

	dim_t cols_lim;
	logic accept;

	// line memories hold at most MAX_COLS pixels
	assign cols_lim = (cols > dim_t'(MAX_COLS)) ? dim_t'(MAX_COLS) : cols;
	assign accept = start && !busy;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= run_end;
			if (accept) begin
				busy <= 1'b1;
			end else if (run_end) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cfg_base <= base_addr;
			cfg_row_bytes <= row_bytes;
			cfg_rows <= rows;
			cfg_cols <= cols_lim;
			cfg_layers <= layers;
			// beats per row, rounded up
			row_beats <= burst_len_t'((int'(cols_lim) + PIX_PER_BEAT - 1) / PIX_PER_BEAT);
		end
	end

endmodule

//--- src/window_sequencer.sv
module window_sequencer import geometry_pkg::*, ddr_read_pkg::*; #(
	parameter int LAYER_SHIFT = 13
) (
	input logic clk,
	input logic reset_n,
	input logic busy,
	input logic start,
	input addr_t cfg_base,
	input addr_t cfg_row_bytes,
	input dim_t cfg_rows,
	input dim_t cfg_layers,
	row_fetch_if.requester fetch,
	output logic [2:0] row_blank,
	output logic sweep_start,
	output dim_t cur_layer,
	input logic sweep_done,
	output logic run_end
);

	typedef enum logic [1:0] {IDLE, REQ, WAIT_DROP, SWEEP} state_t;

	state_t state;
	dim_t row;
	dim_t layer;
	logic [1:0] line_idx;
	dim_t fetch_row;
	logic last_row;
	logic last_layer;
	logic line_finish;

	assign last_row = (row + dim_t'(1)) == cfg_rows;
	assign last_layer = (layer + dim_t'(1)) == cfg_layers;

	// line 0 is the row above, line 2 the row below
	assign row_blank = {last_row, 1'b0, row == '0};

	// ---------------------------------------------------------------------------
	// row fetch request
	// ---------------------------------------------------------------------------
	assign fetch_row = row + dim_t'(line_idx) - dim_t'(1);
	assign fetch.row_addr = cfg_base + (addr_t'(layer) << LAYER_SHIFT)
		+ addr_t'(fetch_row) * cfg_row_bytes;
	assign fetch.line_sel = line_idx;
	assign fetch.req = (state == REQ) && !row_blank[line_idx];

	// blank lines are skipped, fetched ones finish once ack drops
	assign line_finish = ((state == REQ) && row_blank[line_idx])
		|| ((state == WAIT_DROP) && !fetch.ack);

	assign cur_layer = layer;
	assign run_end = (state == SWEEP) && sweep_done && last_layer && last_row;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
			row <= '0;
			layer <= '0;
			line_idx <= '0;
			sweep_start <= 1'b0;
		end else begin
			sweep_start <= 1'b0;
			case (state)
				IDLE: begin
					if (start && !busy) begin
						row <= '0;
						layer <= '0;
						line_idx <= '0;
						state <= REQ;
					end
				end
				REQ: begin
					if (fetch.req && fetch.ack) begin
						state <= WAIT_DROP;
					end
				end
				WAIT_DROP: begin
					// left by line_finish below
				end
				SWEEP: begin
					if (sweep_done) begin
						line_idx <= '0;
						if (!last_layer) begin
							layer <= layer + dim_t'(1);
							state <= REQ;
						end else if (!last_row) begin
							layer <= '0;
							row <= row + dim_t'(1);
							state <= REQ;
						end else begin
							state <= IDLE;
						end
					end
				end
				default: state <= IDLE;
			endcase

			if (line_finish) begin
				if (line_idx == 2'd2) begin
					sweep_start <= 1'b1;
					state <= SWEEP;
				end else begin
					line_idx <= line_idx + 2'd1;
					state <= REQ;
				end
			end
		end
	end

endmodule

//--- src/ddr_burst_reader.sv
module ddr_burst_reader import ddr_read_pkg::*; (
	input logic clk,
	input logic reset_n,
	input burst_len_t row_beats,
	row_fetch_if.server fetch,
	line_write_if.source wr,
	output addr_t ar_addr,
	output burst_len_t ar_len,
	output logic [2:0] ar_size,
	output logic [1:0] ar_burst,
	output logic [3:0] ar_id,
	output logic ar_valid,
	input logic ar_ready,
	input beat_t r_data,
	input logic r_last,
	input logic r_valid,
	output logic r_ready
);

	typedef enum logic [1:0] {IDLE, ADDR, DATA, ACK} state_t;

	state_t state;
	burst_len_t beat_cnt;
	logic [1:0] line_q;

	assign ar_size = AR_SIZE_16B;
	assign ar_burst = AR_BURST_INCR;
	assign ar_id = READ_ID;

	assign ar_valid = (state == ADDR);
	assign r_ready = (state == DATA);
	assign fetch.ack = (state == ACK);

	// every accepted beat goes straight into the line
	assign wr.we = r_valid && r_ready;
	assign wr.line_sel = line_q;
	assign wr.beat_idx = beat_cnt;
	assign wr.data = r_data;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (fetch.req) begin
						state <= ADDR;
					end
				end
				ADDR: begin
					if (ar_ready) begin
						beat_cnt <= '0;
						state <= DATA;
					end
				end
				DATA: begin
					if (r_valid) begin
						beat_cnt <= beat_cnt + burst_len_t'(1);
						if (r_last) begin
							state <= ACK;
						end
					end
				end
				ACK: begin
					// wait for the requester to drop req
					if (!fetch.req) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// request fields captured as the burst is taken on
	always_ff @(posedge clk) begin
		if (state == IDLE && fetch.req) begin
			ar_addr <= fetch.row_addr;
			ar_len <= row_beats - burst_len_t'(1);
			line_q <= fetch.line_sel;
		end
	end

endmodule

//--- src/line_buffers.sv
module line_buffers import geometry_pkg::*; #(
	parameter int MAX_COLS = 64
) (
	input logic clk,
	line_write_if.sink wr,
	input logic [2:0] row_blank,
	input dim_t col,
	output window_t taps
);

	// whole beats plus one spare, so reads at col + 2 stay inside
	localparam int LINE_BEATS = (MAX_COLS + PIX_PER_BEAT - 1) / PIX_PER_BEAT + 1;
	localparam int DEPTH = LINE_BEATS * PIX_PER_BEAT;
	localparam int PW = $bits(pixel_t);

	pixel_t mem [3][DEPTH];

	// ---------------------------------------------------------------------------
	// beat write, eight pixels at once
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr.we) begin
			for (int p = 0; p < PIX_PER_BEAT; p++) begin
				mem[wr.line_sel][int'(wr.beat_idx) * PIX_PER_BEAT + p] <= wr.data[PW*p +: PW];
			end
		end
	end

	// ---------------------------------------------------------------------------
	// three-pixel read per line
	// ---------------------------------------------------------------------------
	always_comb begin
		taps = '0;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				// rows outside the image read as zero
				if (!row_blank[i]) begin
					taps[PW*(3*i + j) +: PW] = mem[i][int'(col) + j];
				end
			end
		end
	end

endmodule

//--- src/window_stream.sv
module window_stream import geometry_pkg::*; #(
	parameter int MAX_COLS = 64
) (
	input logic clk,
	input logic reset_n,
	input logic sweep_start,
	input dim_t cfg_cols,
	input dim_t cur_layer,
	output dim_t col,
	input window_t taps,
	output window_t window_data,
	output dim_t window_layer,
	output logic window_valid,
	input logic window_ready,
	output logic sweep_done
);

	localparam int PW = $bits(pixel_t);

	dim_t col_end;
	logic pending;
	logic out_last;
	logic load;
	logic last_col;
	window_t masked;

	assign col_end = (cfg_cols > dim_t'(MAX_COLS)) ? dim_t'(MAX_COLS) : cfg_cols;
	assign last_col = (col + dim_t'(1)) == col_end;

	// load into an empty register or alongside a transfer
	assign load = pending && (!window_valid || window_ready);
	assign sweep_done = window_valid && window_ready && out_last;

	// right-edge zero padding
	always_comb begin
		masked = taps;
		for (int j = 0; j < 3; j++) begin
			if (int'(col) + j >= int'(col_end)) begin
				for (int i = 0; i < 3; i++) begin
					masked[PW*(3*i + j) +: PW] = '0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pending <= 1'b0;
			col <= '0;
			window_valid <= 1'b0;
			out_last <= 1'b0;
		end else begin
			if (sweep_start) begin
				pending <= 1'b1;
				col <= '0;
			end else if (load) begin
				if (last_col) begin
					pending <= 1'b0;
				end else begin
					col <= col + dim_t'(1);
				end
			end

			if (load) begin
				window_valid <= 1'b1;
				out_last <= last_col;
			end else if (window_ready) begin
				window_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			window_data <= masked;
			window_layer <= cur_layer;
		end
	end

endmodule

//--- src/input_layer_reader.sv
module input_layer_reader import geometry_pkg::*, ddr_read_pkg::*; #(
	parameter int MAX_COLS = 64,
	parameter int LAYER_SHIFT = 13
) (
	input logic clk,
	input logic reset_n,
	input logic start,
	input addr_t base_addr,
	input dim_t rows,
	input dim_t cols,
	input dim_t layers,
	input addr_t row_bytes,
	output addr_t ar_addr,
	output burst_len_t ar_len,
	output logic [2:0] ar_size,
	output logic [1:0] ar_burst,
	output logic [3:0] ar_id,
	output logic ar_valid,
	input logic ar_ready,
	input beat_t r_data,
	input logic r_last,
	input logic r_valid,
	output logic r_ready,
	output window_t window_data,
	output dim_t window_layer,
	output logic window_valid,
	input logic window_ready,
	output logic done
);

	addr_t cfg_base;
	addr_t cfg_row_bytes;
	dim_t cfg_rows;
	dim_t cfg_cols;
	dim_t cfg_layers;
	burst_len_t row_beats;
	logic busy;
	logic run_end;
	logic [2:0] row_blank;
	logic sweep_start;
	logic sweep_done;
	dim_t cur_layer;
	dim_t col;
	window_t taps;

	row_fetch_if fetch_bus ();
	line_write_if line_bus ();

	// ---------------------------------------------------------------------------
	// control
	// ---------------------------------------------------------------------------
	reader_config #(.MAX_COLS(MAX_COLS)) u_config (
		.clk(clk), .reset_n(reset_n), .start(start), .run_end(run_end),
		.base_addr(base_addr), .rows(rows), .cols(cols), .layers(layers),
		.row_bytes(row_bytes), .cfg_base(cfg_base), .cfg_row_bytes(cfg_row_bytes),
		.cfg_rows(cfg_rows), .cfg_cols(cfg_cols), .cfg_layers(cfg_layers),
		.row_beats(row_beats), .busy(busy), .done(done)
	);

	window_sequencer #(.LAYER_SHIFT(LAYER_SHIFT)) u_sequencer (
		.clk(clk), .reset_n(reset_n), .busy(busy), .start(start),
		.cfg_base(cfg_base), .cfg_row_bytes(cfg_row_bytes), .cfg_rows(cfg_rows),
		.cfg_layers(cfg_layers), .fetch(fetch_bus.requester), .row_blank(row_blank),
		.sweep_start(sweep_start), .cur_layer(cur_layer), .sweep_done(sweep_done),
		.run_end(run_end)
	);

	// ---------------------------------------------------------------------------
	// DDR fetch into the line memories
	// ---------------------------------------------------------------------------
	ddr_burst_reader u_burst_reader (
		.clk(clk), .reset_n(reset_n), .row_beats(row_beats),
		.fetch(fetch_bus.server), .wr(line_bus.source),
		.ar_addr(ar_addr), .ar_len(ar_len), .ar_size(ar_size), .ar_burst(ar_burst),
		.ar_id(ar_id), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r_data(r_data), .r_last(r_last), .r_valid(r_valid), .r_ready(r_ready)
	);

	line_buffers #(.MAX_COLS(MAX_COLS)) u_lines (
		.clk(clk), .wr(line_bus.sink), .row_blank(row_blank), .col(col), .taps(taps)
	);

	// window output
	window_stream #(.MAX_COLS(MAX_COLS)) u_stream (
		.clk(clk), .reset_n(reset_n), .sweep_start(sweep_start), .cfg_cols(cfg_cols),
		.cur_layer(cur_layer), .col(col), .taps(taps), .window_data(window_data),
		.window_layer(window_layer), .window_valid(window_valid),
		.window_ready(window_ready), .sweep_done(sweep_done)
	);

endmodule

//--- verif/window_checker.sv
module window_checker import geometry_pkg::*, ddr_read_pkg::*; #(
	parameter int LAYER_SHIFT = 13
) (
	input logic clk,
	input logic reset_n,
	input logic start,
	input addr_t base_addr,
	input dim_t rows,
	input dim_t cols,
	input dim_t layers,
	input addr_t row_bytes,
	input logic [15:0] salt,
	input int exp_beats,
	input int exp_windows,
	input addr_t ar_addr,
	input burst_len_t ar_len,
	input logic [2:0] ar_size,
	input logic [1:0] ar_burst,
	input logic [3:0] ar_id,
	input logic ar_valid,
	input logic ar_ready,
	input logic r_last,
	input logic r_valid,
	input logic r_ready,
	input window_t window_data,
	input dim_t window_layer,
	input logic window_valid,
	input logic window_ready,
	input logic done,
	output int error_count,
	output int test_count,
	output int window_count
);

	timeunit 1ns;
	timeprecision 1ps;

	// geometry of the running test
	addr_t g_base;
	addr_t g_row_bytes;
	int g_rows;
	int g_cols;
	int g_layers;
	int g_beats;
	int g_windows;
	logic [15:0] g_salt;

	int row;
	int layer;
	int col;
	int seen;
	int beats;
	int errors_before;
	logic active;
	logic in_burst;
	logic stalled;
	window_t held;
	addr_t bursts [$];

	function automatic addr_t row_address(input int r, input int l);
		return g_base + (addr_t'(l) << LAYER_SHIFT) + addr_t'(r) * g_row_bytes;
	endfunction

	// zero above, below and right of the image
	function automatic pixel_t expected_pixel(input int r, input int l, input int c);
		addr_t a;
		if (r < 0 || r >= g_rows || c >= g_cols) begin
			return '0;
		end
		a = row_address(r, l) + addr_t'(2 * c);
		return pixel_t'((a >> 1) ^ addr_t'(g_salt));
	endfunction

	function automatic window_t expected_window(input int r, input int l, input int c);
		window_t w;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				w[16*(3*i + j) +: 16] = expected_pixel(r + i - 1, l, c + j);
			end
		end
		return w;
	endfunction

	task automatic report_mismatch(input string name, input logic [143:0] got,
		input logic [143:0] want);
		$display("MISMATCH time %0d ns: %s got %0h expected %0h", $time, name, got, want);
		error_count++;
	endtask

	task automatic report_failure(input string what);
		$display("ERROR time %0d ns: %s", $time, what);
		error_count++;
	endtask

	// ---------------------------------------------------------------------------
	// per-test bookkeeping
	// ---------------------------------------------------------------------------
	task automatic open_test();
		int rr;
		g_base = base_addr;
		g_row_bytes = row_bytes;
		g_rows = int'(rows);
		g_cols = int'(cols);
		g_layers = int'(layers);
		g_salt = salt;
		g_beats = exp_beats;
		g_windows = exp_windows;
		row = 0;
		layer = 0;
		col = 0;
		seen = 0;
		beats = 0;
		errors_before = error_count;
		bursts.delete();
		// rows above, at and below each output row that lie inside the image
		for (int r = 0; r < g_rows; r++) begin
			for (int l = 0; l < g_layers; l++) begin
				for (int i = 0; i < 3; i++) begin
					rr = r + i - 1;
					if (rr >= 0 && rr < g_rows) begin
						bursts.push_back(row_address(rr, l));
					end
				end
			end
		end
		active = 1'b1;
	endtask

	task automatic check_burst();
		addr_t want;
		if (ar_size != 3'd4) report_mismatch("ar_size", ar_size, 4);
		if (ar_burst != 2'd1) report_mismatch("ar_burst", ar_burst, 1);
		if (ar_id != 4'd1) report_mismatch("ar_id", ar_id, 1);
		if (int'(ar_len) != g_beats - 1) report_mismatch("ar_len", ar_len, g_beats - 1);
		if (bursts.size() == 0) begin
			report_failure("read burst issued with no row left to fetch");
		end else begin
			want = bursts.pop_front();
			if (ar_addr != want) report_mismatch("ar_addr", ar_addr, want);
		end
		beats = 0;
		in_burst = 1'b1;
	endtask

	task automatic check_window();
		window_t want;
		if (!active) begin
			report_failure("window transferred with no test running");
		end else begin
			want = expected_window(row, layer, col);
			if (window_data !== want) report_mismatch("window_data", window_data, want);
			if (int'(window_layer) != layer) begin
				report_mismatch("window_layer", window_layer, layer);
			end
			seen++;
			window_count++;
			col++;
			if (col == g_cols) begin
				col = 0;
				layer++;
				if (layer == g_layers) begin
					layer = 0;
					row++;
				end
			end
		end
	endtask

	task automatic close_test();
		if (!active) begin
			report_failure("done pulsed with no test running");
		end else begin
			if (seen != g_windows) report_mismatch("window count", seen, g_windows);
			if (bursts.size() != 0) report_failure("done pulsed before every row was fetched");
			$display("test %0d: rows %0d cols %0d layers %0d, %0d windows, %0d errors",
				test_count, g_rows, g_cols, g_layers, seen, error_count - errors_before);
			test_count++;
			active = 1'b0;
		end
	endtask

	always @(posedge clk) begin
		if (!reset_n) begin
			error_count = 0;
			test_count = 0;
			window_count = 0;
			active = 1'b0;
			in_burst = 1'b0;
			stalled = 1'b0;
		end else begin
			if (start) begin
				if (active) report_failure("start pulsed while a test was running");
				open_test();
			end
			if (ar_valid && ar_ready) check_burst();
			// read data is taken only inside a burst
			if (r_ready && !in_burst) begin
				report_failure("r_ready high with no read burst outstanding");
			end
			if (r_valid && r_ready) begin
				beats++;
				if (r_last) begin
					if (beats != g_beats) report_mismatch("r beats", beats, g_beats);
					in_burst = 1'b0;
				end
			end
			// output must hold under back-pressure
			if (stalled && (!window_valid || window_data !== held)) begin
				report_failure("window changed while window_ready was low");
			end
			stalled = window_valid && !window_ready;
			held = window_data;
			if (window_valid && window_ready) check_window();
			if (done) close_test();
		end
	end

endmodule

//--- verif/tb_input_layer_reader.sv
module tb_input_layer_reader import geometry_pkg::*, ddr_read_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_COLS = 64;
	localparam int LAYER_SHIFT = 13;
	localparam int NUM_TESTS = 6;
	localparam logic [31:0] SEED = 32'h37d6_61c5;

	typedef struct packed {
		addr_t base;
		int rows;
		int cols;
		int layers;
		addr_t row_bytes;
		int stall_pct;
		int beats;
		int windows;
	} test_t;

	// base, rows, cols, layers, row bytes, stall %, beats per row, windows
	localparam test_t TESTS [NUM_TESTS] = '{
		'{32'h0001_0000, 4, 16, 1, 32'd64, 0, 2, 64},
		'{32'h0002_0000, 3, 5, 1, 32'd16, 0, 1, 15},
		'{32'h0004_0000, 5, 13, 2, 32'd32, 20, 2, 130},
		'{32'h0010_0000, 3, 24, 3, 32'd64, 40, 3, 216},
		'{32'h0020_0000, 1, 8, 2, 32'd16, 30, 1, 16},
		'{32'h0030_0000, 2, 64, 1, 32'd128, 25, 8, 128}
	};

	logic clk = 1'b0;
	logic reset_n = 1'b0;
	logic start = 1'b0;
	addr_t base_addr = '0;
	dim_t rows = '0;
	dim_t cols = '0;
	dim_t layers = '0;
	addr_t row_bytes = '0;
	addr_t ar_addr;
	burst_len_t ar_len;
	logic [2:0] ar_size;
	logic [1:0] ar_burst;
	logic [3:0] ar_id;
	logic ar_valid;
	logic ar_ready = 1'b0;
	beat_t r_data = '0;
	logic r_last = 1'b0;
	logic r_valid = 1'b0;
	logic r_ready;
	window_t window_data;
	dim_t window_layer;
	logic window_valid;
	logic window_ready = 1'b0;
	logic done;

	logic [15:0] salt = '0;
	int stall_pct = 0;
	int exp_beats = 0;
	int exp_windows = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int error_count;
	int test_count;
	int window_count;
	logic [31:0] stall_state = SEED;

	// burst being served by the memory model
	logic rd_busy = 1'b0;
	addr_t rd_addr = '0;
	burst_len_t rd_len = '0;
	burst_len_t rd_beat = '0;

	always #50 clk = ~clk;

	input_layer_reader #(.MAX_COLS(MAX_COLS), .LAYER_SHIFT(LAYER_SHIFT)) u_dut (.*);

	window_checker #(.LAYER_SHIFT(LAYER_SHIFT)) u_check (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic stall_roll(input int pct);
		stall_state = lcg_next(stall_state);
		return int'(stall_state[31:16] % 16'd100) < pct;
	endfunction

	// each 16-bit lane holds its half-word address mixed with the salt
	function automatic beat_t beat_data(input addr_t addr, input logic [15:0] s);
		beat_t d;
		addr_t a;
		for (int p = 0; p < PIX_PER_BEAT; p++) begin
			a = addr + addr_t'(2 * p);
			d[16*p +: 16] = a[16:1] ^ s;
		end
		return d;
	endfunction

	// ---------------------------------------------------------------------------
	// AXI read slave and stream sink
	// ---------------------------------------------------------------------------
	always @(posedge clk) begin
		if (!reset_n) begin
			ar_ready <= 1'b0;
			r_valid <= 1'b0;
			r_last <= 1'b0;
			rd_busy <= 1'b0;
			window_ready <= 1'b0;
		end else begin
			window_ready <= !stall_roll(stall_pct);
			if (!rd_busy) begin
				if (ar_valid && ar_ready) begin
					rd_busy <= 1'b1;
					rd_addr <= ar_addr;
					rd_len <= ar_len;
					rd_beat <= '0;
					ar_ready <= 1'b0;
				end else begin
					ar_ready <= ar_valid && !stall_roll(stall_pct);
				end
			end else if (!r_valid || r_ready) begin
				if (r_valid && r_last) begin
					r_valid <= 1'b0;
					r_last <= 1'b0;
					rd_busy <= 1'b0;
				end else if (stall_roll(stall_pct)) begin
					r_valid <= 1'b0;
				end else begin
					r_valid <= 1'b1;
					r_data <= beat_data(rd_addr + addr_t'(rd_beat) * 32'd16, salt);
					r_last <= (rd_beat == rd_len);
					rd_beat <= rd_beat + 1'b1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run still busy after %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ---------------------------------------------------------------------------
	// test sequence
	// ---------------------------------------------------------------------------
	initial begin
		logic [31:0] salt_state;
		int limit;
		salt_state = SEED;
		limit = 1000;
		for (int t = 0; t < NUM_TESTS; t++) begin
			limit += TESTS[t].rows * TESTS[t].layers
				* (4 * TESTS[t].cols + 3 * (TESTS[t].beats + 20));
		end
		cycle_limit = limit;
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;
		for (int t = 0; t < NUM_TESTS; t++) begin
			@(posedge clk);
			salt_state = lcg_next(salt_state);
			base_addr <= TESTS[t].base;
			rows <= dim_t'(TESTS[t].rows);
			cols <= dim_t'(TESTS[t].cols);
			layers <= dim_t'(TESTS[t].layers);
			row_bytes <= TESTS[t].row_bytes;
			stall_pct <= TESTS[t].stall_pct;
			exp_beats <= TESTS[t].beats;
			exp_windows <= TESTS[t].windows;
			salt <= salt_state[31:16];
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
			do @(posedge clk); while (!done);
		end
		repeat (5) @(posedge clk);
		$display("tests %0d of %0d, windows %0d, errors %0d",
			test_count, NUM_TESTS, window_count, error_count);
		if (error_count == 0 && test_count == NUM_TESTS) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
src/geometry_pkg.sv
src/ddr_read_pkg.sv
src/reader_ifs.sv
src/reader_config.sv
src/window_sequencer.sv
src/ddr_burst_reader.sv
src/line_buffers.sv
src/window_stream.sv
src/input_layer_reader.sv
verif/window_checker.sv
verif/tb_input_layer_reader.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_input_layer_reader
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0 --timescale 1ns/1ps -Wno-fatal
PASS_MSG ?= SIMULATION PASSED

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
